//--- hw/tscPkg.sv
`default_nettype none

package tscPkg;

	// ####################
	// widths
	typedef logic [15:0] wordT;
	typedef logic [1:0] regIdxT;
	typedef logic [3:0] opcodeT;
	typedef logic [5:0] funcT;

	// ####################
	// opcodes
	localparam opcodeT BNE_OP = 4'd0;
	localparam opcodeT BEQ_OP = 4'd1;
	localparam opcodeT BGZ_OP = 4'd2;
	localparam opcodeT BLZ_OP = 4'd3;
	localparam opcodeT ADI_OP = 4'd4;
	localparam opcodeT ORI_OP = 4'd5;
	localparam opcodeT LHI_OP = 4'd6;
	localparam opcodeT LWD_OP = 4'd7;
	localparam opcodeT SWD_OP = 4'd8;
	localparam opcodeT JMP_OP = 4'd9;
	localparam opcodeT JAL_OP = 4'd10;
	localparam opcodeT R_OP = 4'd15; // all func-coded instructions

	// function field of R_OP
	localparam funcT FUNC_ADD = 6'd0;
	localparam funcT FUNC_SUB = 6'd1;
	localparam funcT FUNC_AND = 6'd2;
	localparam funcT FUNC_ORR = 6'd3;
	localparam funcT FUNC_NOT = 6'd4;
	localparam funcT FUNC_TCP = 6'd5;
	localparam funcT FUNC_SHL = 6'd6;
	localparam funcT FUNC_SHR = 6'd7;
	localparam funcT FUNC_JPR = 6'd25;
	localparam funcT FUNC_JRL = 6'd26;
	localparam funcT FUNC_WWD = 6'd28;
	localparam funcT FUNC_HLT = 6'd29;

	localparam regIdxT LINK_REG = 2'd2; // JAL/JRL return address

	// ####################
	// control encodings
	typedef enum logic [3:0] {ADD, SUB, AND, ORR, NOT, TCP, SHL, SHR, LHI} aluOpT;
	typedef enum logic [1:0] {SEQ, BRANCH, JUMP, REG} pcSrcT;
	typedef enum logic [1:0] {RCLASS, ICLASS, JCLASS, NONE} instClassT;
	typedef enum logic {RUN, HALT} coreStateT;

endpackage

`default_nettype wire

//--- hw/fetchUnit.sv
`default_nettype none

module fetchUnit (
	input wire logic clk,
	input wire logic rst,
	input wire logic running,
	input wire tscPkg::pcSrcT pcSrc,
	input wire logic branchTaken,
	input wire tscPkg::wordT immExt,
	input wire logic [11:0] target,
	input wire tscPkg::wordT regTarget,
	output tscPkg::wordT pc,
	output tscPkg::wordT pcNext1
);

	tscPkg::wordT nextPc;

	assign pcNext1 = pc + 16'd1;

	always_comb begin
		case (pcSrc)
			tscPkg::BRANCH: nextPc = branchTaken ? pcNext1 + immExt : pcNext1;
			tscPkg::JUMP: nextPc = {pc[15:12], target}; // stays in current 4K page
			tscPkg::REG: nextPc = regTarget; // JPR / JRL
			default: nextPc = pcNext1;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			pc <= '0;
		else if (running)
			pc <= nextPc;
	end

	// halted core must not move the PC
	pcHold: assert property (@(posedge clk) disable iff (rst) !running |=> $stable(pc));

endmodule

`default_nettype wire

//--- hw/controlUnit.sv
`default_nettype none

module controlUnit (
	input wire logic clk,
	input wire logic rst,
	input wire tscPkg::wordT instData,
	output tscPkg::pcSrcT pcSrc,
	output logic regWrite,
	output logic aluSrcImm,
	output tscPkg::aluOpT aluOp,
	output logic memToReg,
	output logic memRead,
	output logic memWrite,
	output logic branchOp,
	output logic isWwd,
	output logic linkWrite,
	output tscPkg::regIdxT destReg,
	output tscPkg::instClassT instClass,
	output logic running
);

	tscPkg::opcodeT opcode;
	tscPkg::funcT func;
	tscPkg::coreStateT state;
	logic regWriteDec, memReadDec, memWriteDec, isWwdDec, haltDec;

	assign opcode = instData[15:12];
	assign func = instData[5:0];

	// ####################
	// decode
	always_comb begin
		pcSrc = tscPkg::SEQ; // safe defaults, also for unknown codes
		regWriteDec = 1'b0;
		aluSrcImm = 1'b0;
		aluOp = tscPkg::ADD;
		memToReg = 1'b0;
		memReadDec = 1'b0;
		memWriteDec = 1'b0;
		branchOp = 1'b0;
		isWwdDec = 1'b0;
		linkWrite = 1'b0;
		haltDec = 1'b0;
		instClass = tscPkg::ICLASS;
		case (opcode)
			tscPkg::R_OP: begin
				instClass = tscPkg::RCLASS;
				case (func)
					tscPkg::FUNC_ADD: aluOp = tscPkg::ADD;
					tscPkg::FUNC_SUB: aluOp = tscPkg::SUB;
					tscPkg::FUNC_AND: aluOp = tscPkg::AND;
					tscPkg::FUNC_ORR: aluOp = tscPkg::ORR;
					tscPkg::FUNC_NOT: aluOp = tscPkg::NOT;
					tscPkg::FUNC_TCP: aluOp = tscPkg::TCP;
					tscPkg::FUNC_SHL: aluOp = tscPkg::SHL;
					tscPkg::FUNC_SHR: aluOp = tscPkg::SHR;
					tscPkg::FUNC_JPR: pcSrc = tscPkg::REG;
					tscPkg::FUNC_JRL: begin
						pcSrc = tscPkg::REG;
						regWriteDec = 1'b1;
						linkWrite = 1'b1;
					end
					tscPkg::FUNC_WWD: isWwdDec = 1'b1;
					tscPkg::FUNC_HLT: haltDec = 1'b1;
					default: instClass = tscPkg::NONE;
				endcase
				if (func <= tscPkg::FUNC_SHR)
					regWriteDec = 1'b1; // plain ALU ops
			end
			tscPkg::ADI_OP, tscPkg::ORI_OP, tscPkg::LHI_OP, tscPkg::LWD_OP: begin
				regWriteDec = 1'b1;
				aluSrcImm = 1'b1;
				if (opcode == tscPkg::ORI_OP)
					aluOp = tscPkg::ORR;
				else if (opcode == tscPkg::LHI_OP)
					aluOp = tscPkg::LHI;
				memToReg = (opcode == tscPkg::LWD_OP);
				memReadDec = (opcode == tscPkg::LWD_OP);
			end
			tscPkg::SWD_OP: begin
				aluSrcImm = 1'b1; // address = rs + imm
				memWriteDec = 1'b1;
			end
			tscPkg::BNE_OP, tscPkg::BEQ_OP, tscPkg::BGZ_OP, tscPkg::BLZ_OP: begin
				pcSrc = tscPkg::BRANCH;
				branchOp = 1'b1; // compare rs against rt, not imm
			end
			tscPkg::JMP_OP, tscPkg::JAL_OP: begin
				instClass = tscPkg::JCLASS;
				pcSrc = tscPkg::JUMP;
				regWriteDec = (opcode == tscPkg::JAL_OP);
				linkWrite = (opcode == tscPkg::JAL_OP);
			end
			default: instClass = tscPkg::NONE;
		endcase
	end

	always_comb begin
		if (linkWrite)
			destReg = tscPkg::LINK_REG;
		else if (instClass == tscPkg::RCLASS)
			destReg = instData[7:6]; // rd
		else
			destReg = instData[9:8]; // rt
	end

	// ####################
	// run / halt
	always_ff @(posedge clk) begin
		if (rst)
			state <= tscPkg::RUN;
		else if (running && haltDec)
			state <= tscPkg::HALT;
	end

	assign running = (state == tscPkg::RUN);
	assign regWrite = regWriteDec && running;
	assign memRead = memReadDec && running;
	assign memWrite = memWriteDec && running;
	assign isWwd = isWwdDec && running;

	noWriteConflict: assert property (@(posedge clk) disable iff (rst) !(regWrite && memWrite));
	quietInHalt: assert property (@(posedge clk) disable iff (rst)
		state == tscPkg::HALT |-> !(regWrite || memRead || memWrite || isWwd));

endmodule

`default_nettype wire

//--- hw/registerFile.sv
`default_nettype none

module registerFile (
	input wire logic clk,
	input wire logic rst,
	input wire tscPkg::regIdxT rsIdx,
	input wire tscPkg::regIdxT rtIdx,
	input wire tscPkg::regIdxT writeIdx,
	input wire logic writeEn,
	input wire tscPkg::wordT writeValue,
	output tscPkg::wordT rsValue,
	output tscPkg::wordT rtValue
);

	tscPkg::wordT regs [4];

	// async read, same-cycle decode depends on it
	assign rsValue = regs[rsIdx];
	assign rtValue = regs[rtIdx];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 4; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn) begin
			regs[writeIdx] <= writeValue;
		end
	end

endmodule

`default_nettype wire

//--- hw/alu.sv
`default_nettype none

module alu (
	input wire tscPkg::aluOpT aluOp,
	input wire tscPkg::wordT opA,
	input wire tscPkg::wordT opB,
	input wire logic branchOp,
	input wire tscPkg::opcodeT opcode,
	output tscPkg::wordT aluResult,
	output logic branchTaken
);

	tscPkg::wordT orOperand;
	logic cond;

	always_comb begin
		// ORI takes its immediate zero-extended
		orOperand = (opcode == tscPkg::ORI_OP) ? {8'h00, opB[7:0]} : opB;
		case (aluOp)
			tscPkg::ADD: aluResult = opA + opB;
			tscPkg::SUB: aluResult = opA - opB;
			tscPkg::AND: aluResult = opA & opB;
			tscPkg::ORR: aluResult = opA | orOperand;
			tscPkg::NOT: aluResult = ~opA;
			tscPkg::TCP: aluResult = ~opA + 16'd1;
			tscPkg::SHL: aluResult = {opA[14:0], 1'b0};
			tscPkg::SHR: aluResult = {1'b0, opA[15:1]}; // logical
			tscPkg::LHI: aluResult = {opB[7:0], 8'h00};
			default: aluResult = opA;
		endcase
	end

	// ####################
	// branch condition
	always_comb begin
		case (opcode)
			tscPkg::BNE_OP: cond = (opA != opB);
			tscPkg::BEQ_OP: cond = (opA == opB);
			tscPkg::BGZ_OP: cond = !opA[15] && (opA != '0);
			tscPkg::BLZ_OP: cond = opA[15];
			default: cond = 1'b0;
		endcase
		branchTaken = branchOp && cond;
	end

endmodule

`default_nettype wire

//--- hw/memOutUnit.sv
`default_nettype none

module memOutUnit (
	input wire logic clk,
	input wire logic rst,
	input wire tscPkg::wordT aluResult,
	input wire tscPkg::wordT rtValue,
	input wire tscPkg::wordT rsValue,
	input wire tscPkg::wordT pcNext1,
	input wire logic memRead,
	input wire logic memWrite,
	input wire logic memToReg,
	input wire logic linkWrite,
	input wire logic isWwd,
	input wire tscPkg::wordT dataReadValue,
	output tscPkg::wordT dataAddr,
	output tscPkg::wordT dataWriteValue,
	output logic memReadStrobe,
	output logic memWriteStrobe,
	output tscPkg::wordT writeValue,
	output tscPkg::wordT outputPort,
	output logic outputValid
);

	// data memory side, address is rs + imm
	assign dataAddr = aluResult;
	assign dataWriteValue = rtValue;
	assign memReadStrobe = memRead;
	assign memWriteStrobe = memWrite;

	always_comb begin
		if (linkWrite)
			writeValue = pcNext1; // return address
		else if (memToReg)
			writeValue = dataReadValue;
		else
			writeValue = aluResult;
	end

	// ####################
	// WWD port, one cycle late
	always_ff @(posedge clk) begin
		if (rst)
			outputValid <= 1'b0;
		else
			outputValid <= isWwd;
	end

	always_ff @(posedge clk) begin
		if (isWwd)
			outputPort <= rsValue;
	end

endmodule

`default_nettype wire

//--- hw/tscCore.sv
`default_nettype none

module tscCore (
	input wire logic clk,
	input wire logic rst,
	input wire tscPkg::wordT instData,
	input wire tscPkg::wordT dataReadValue,
	output tscPkg::wordT instAddr,
	output tscPkg::wordT dataAddr,
	output tscPkg::wordT dataWriteValue,
	output logic memRead,
	output logic memWrite,
	output tscPkg::wordT outputPort,
	output logic outputValid,
	output logic halted
);

	tscPkg::pcSrcT pcSrc;
	tscPkg::aluOpT aluOp;
	tscPkg::regIdxT destReg;
	logic regWrite, aluSrcImm, memToReg, ctrlMemRead, ctrlMemWrite;
	logic branchOp, isWwd, linkWrite, running, branchTaken;
	tscPkg::wordT immExt, pcNext1, rsValue, rtValue, aluOpB, aluResult, writeValue;

	assign immExt = {{8{instData[7]}}, instData[7:0]};
	assign aluOpB = aluSrcImm ? immExt : rtValue;
	assign halted = !running;

	fetchUnit fetch (.clk, .rst, .running, .pcSrc, .branchTaken, .immExt,
		.target(instData[11:0]), .regTarget(rsValue), .pc(instAddr), .pcNext1);

	controlUnit ctrl (.clk, .rst, .instData, .pcSrc, .regWrite, .aluSrcImm, .aluOp,
		.memToReg, .memRead(ctrlMemRead), .memWrite(ctrlMemWrite), .branchOp, .isWwd,
		.linkWrite, .destReg, .instClass(), .running);

	registerFile regFile (.clk, .rst, .rsIdx(instData[11:10]), .rtIdx(instData[9:8]),
		.writeIdx(destReg), .writeEn(regWrite), .writeValue, .rsValue, .rtValue);

	alu exec (.aluOp, .opA(rsValue), .opB(aluOpB), .branchOp,
		.opcode(instData[15:12]), .aluResult, .branchTaken);

	memOutUnit memOut (.clk, .rst, .aluResult, .rtValue, .rsValue, .pcNext1,
		.memRead(ctrlMemRead), .memWrite(ctrlMemWrite), .memToReg, .linkWrite, .isWwd,
		.dataReadValue, .dataAddr, .dataWriteValue, .memReadStrobe(memRead),
		.memWriteStrobe(memWrite), .writeValue, .outputPort, .outputValid);

endmodule

`default_nettype wire

//--- verif/tscCoreTb.sv
`default_nettype none

module tscCoreTb;

	localparam int RUN_TIMEOUT = 2000;
	localparam int HALT_WINDOW = 40;

	logic clk = 1'b0;
	logic rst;
	logic rstDelayed = 1'b0;
	tscPkg::wordT instData, dataReadValue, instAddr, dataAddr, dataWriteValue, outputPort;
	logic memRead, memWrite, outputValid, halted;

	tscPkg::wordT imem [4096];
	tscPkg::wordT dmem [65536];
	tscPkg::wordT modelMem [tscPkg::wordT]; // stores seen by the reference model
	tscPkg::wordT expWwd [64];
	tscPkg::wordT storeAddr [8];
	tscPkg::wordT storeVal [8];
	tscPkg::wordT loadAddr [8];
	tscPkg::wordT expHaltPc;
	int expCount, storeCount, loadCount, wwdIdx, storeIdx, loadIdx, progLen;
	int errors = 0;
	int passCount = 0;
	logic [15:0] lfsr = 16'd85;

	tscCore DUT (.clk(clk), .rst(rst), .instData(instData), .dataReadValue(dataReadValue),
		.instAddr(instAddr), .dataAddr(dataAddr), .dataWriteValue(dataWriteValue),
		.memRead(memRead), .memWrite(memWrite), .outputPort(outputPort),
		.outputValid(outputValid), .halted(halted));

	always #2 clk = ~clk;

	// ####################
	// memories
	assign instData = imem[instAddr[11:0]];
	assign dataReadValue = dmem[dataAddr];

	function automatic tscPkg::wordT fillPattern(tscPkg::wordT addr);
		return {addr[7:0], addr[15:8]} ^ 16'h3c5a;
	endfunction

	initial begin
		for (int i = 0; i < 65536; i++)
			dmem[i] = fillPattern(i[15:0]);
	end

	always @(posedge clk) begin
		rstDelayed <= rst;
		if (memWrite)
			dmem[dataAddr] <= dataWriteValue;
		if (rst) begin
			wwdIdx <= 0;
			storeIdx <= 0;
			loadIdx <= 0;
		end else begin
			if (outputValid)
				wwdIdx <= wwdIdx + 1;
			if (memWrite)
				storeIdx <= storeIdx + 1;
			if (memRead)
				loadIdx <= loadIdx + 1;
		end
	end

	// ####################
	// reporting
	task automatic reportValue(string name, tscPkg::wordT got, tscPkg::wordT exp);
		$display("error at %0t: %s = %h, expected %h", $time, name, got, exp);
		errors++;
	endtask

	task automatic reportPlain(string msg);
		$display("at %0t: %s", $time, msg);
		errors++;
	endtask

	task automatic wwdMismatch(tscPkg::wordT got, int idx);
		if (idx >= expCount)
			reportPlain("WWD output appeared that the program does not produce");
		else
			reportValue("outputPort", got, expWwd[idx]);
	endtask

	task automatic storeMismatch(tscPkg::wordT addr, tscPkg::wordT val, int idx);
		if (idx >= storeCount) begin
			reportPlain("data memory write that the program does not produce");
		end else begin
			if (addr != storeAddr[idx])
				reportValue("dataAddr", addr, storeAddr[idx]);
			if (val != storeVal[idx])
				reportValue("dataWriteValue", val, storeVal[idx]);
		end
	endtask

	task automatic loadMismatch(tscPkg::wordT addr, int idx);
		if (idx >= loadCount)
			reportPlain("data memory read that the program does not produce");
		else
			reportValue("dataAddr", addr, loadAddr[idx]);
	endtask

	resetState: assert property (@(posedge clk) rst && rstDelayed |->
		instAddr == '0 && !outputValid && !memWrite && !memRead && !halted)
		else reportPlain("core outputs not cleared by reset");
	wwdValue: assert property (@(posedge clk) disable iff (rst)
		outputValid |-> wwdIdx < expCount && outputPort == expWwd[wwdIdx])
		else wwdMismatch($sampled(outputPort), $sampled(wwdIdx));
	storeValue: assert property (@(posedge clk) disable iff (rst)
		memWrite |-> storeIdx < storeCount && dataAddr == storeAddr[storeIdx]
			&& dataWriteValue == storeVal[storeIdx])
		else storeMismatch($sampled(dataAddr), $sampled(dataWriteValue), $sampled(storeIdx));
	loadValue: assert property (@(posedge clk) disable iff (rst)
		memRead |-> loadIdx < loadCount && dataAddr == loadAddr[loadIdx])
		else loadMismatch($sampled(dataAddr), $sampled(loadIdx));
	haltPc: assert property (@(posedge clk) disable iff (rst) halted |-> instAddr == expHaltPc)
		else reportValue("instAddr", $sampled(instAddr), expHaltPc);
	haltSticky: assert property (@(posedge clk) disable iff (rst) halted |=> halted)
		else reportPlain("halted dropped without a reset");
	haltQuiet: assert property (@(posedge clk) disable iff (rst)
		halted |-> !outputValid && !memWrite)
		else reportPlain("outputValid or memWrite active while halted");

	// ####################
	// program builder
	function automatic tscPkg::wordT randBits(int n);
		tscPkg::wordT v;
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			v = {v[14:0], fb}; // one step per bit
		end
		return v;
	endfunction

	function automatic tscPkg::wordT rInst(tscPkg::funcT f, tscPkg::regIdxT rs,
		tscPkg::regIdxT rt, tscPkg::regIdxT rd);
		return {tscPkg::R_OP, rs, rt, rd, f};
	endfunction

	function automatic tscPkg::wordT iInst(tscPkg::opcodeT op, tscPkg::regIdxT rs,
		tscPkg::regIdxT rt, logic [7:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic void emit(tscPkg::wordT w);
		imem[progLen] = w;
		progLen++;
	endfunction

	function automatic void startProgram();
		progLen = 0;
		for (int i = 0; i < 4096; i++)
			imem[i] = rInst(tscPkg::FUNC_HLT, 0, 0, 0); // runaway code halts
	endfunction

	function automatic void loadReg(tscPkg::regIdxT r, tscPkg::wordT v);
		emit(iInst(tscPkg::LHI_OP, 0, r, v[15:8]));
		emit(iInst(tscPkg::ORI_OP, r, r, v[7:0]));
	endfunction

	function automatic void wwd(tscPkg::regIdxT r);
		emit(rInst(tscPkg::FUNC_WWD, r, 0, 0));
	endfunction

	function automatic void jumpTo(tscPkg::opcodeT op, int target);
		emit({op, target[11:0]});
	endfunction

	function automatic void buildArith();
		startProgram();
		loadReg(0, randBits(16));
		loadReg(1, randBits(16));
		wwd(0);
		wwd(1);
		for (int f = 0; f < 8; f++) begin
			emit(rInst(tscPkg::funcT'(f), 0, 1, 3));
			wwd(3);
		end
		emit(iInst(tscPkg::ADI_OP, 0, 3, randBits(8)));
		wwd(3);
		emit(rInst(tscPkg::FUNC_HLT, 0, 0, 0));
	endfunction

	function automatic void buildMemory();
		logic [7:0] off;
		startProgram();
		off = randBits(8);
		loadReg(0, randBits(16));
		loadReg(1, randBits(16));
		emit(iInst(tscPkg::SWD_OP, 0, 1, off));
		emit(iInst(tscPkg::LWD_OP, 0, 2, off));
		wwd(2);
		emit(iInst(tscPkg::LWD_OP, 0, 3, off + 8'd1)); // neighbour word
		wwd(3);
		emit(rInst(tscPkg::FUNC_HLT, 0, 0, 0));
	endfunction

	function automatic void buildBranches();
		tscPkg::wordT a, b;
		startProgram();
		for (int op = 0; op < 4; op++) begin
			for (int taken = 0; taken < 2; taken++) begin
				a = randBits(16);
				b = '0;
				case (op)
					0: b = taken ? a + 16'd1 : a;
					1: b = taken ? a : a + 16'd1;
					2: a = taken ? {1'b0, a[14:1], 1'b1} : {1'b1, a[14:0]};
					default: a = taken ? {1'b1, a[14:0]} : {1'b0, a[14:0]};
				endcase
				loadReg(0, a);
				loadReg(1, b);
				emit(iInst(tscPkg::opcodeT'(op), 0, 1, 8'd1));
				wwd(0); // skipped when taken
				wwd(1);
			end
		end
		emit(rInst(tscPkg::FUNC_HLT, 0, 0, 0));
	endfunction

	function automatic void buildJumps();
		startProgram();
		loadReg(0, randBits(16));
		jumpTo(tscPkg::JMP_OP, progLen + 2);
		wwd(0);
		jumpTo(tscPkg::JAL_OP, progLen + 2);
		wwd(0);
		wwd(2);
		loadReg(1, progLen + 4);
		emit(rInst(tscPkg::FUNC_JPR, 1, 0, 0));
		wwd(0);
		loadReg(1, progLen + 4);
		emit(rInst(tscPkg::FUNC_JRL, 1, 0, 0));
		wwd(0);
		wwd(2);
		emit(rInst(tscPkg::FUNC_HLT, 0, 0, 0));
	endfunction

	function automatic void buildHalt();
		startProgram();
		loadReg(1, randBits(16));
		wwd(1);
		emit(rInst(tscPkg::FUNC_HLT, 0, 0, 0));
		emit(iInst(tscPkg::SWD_OP, 0, 1, 8'd0)); // never reached
		wwd(1);
	endfunction

	// ####################
	// ISA reference model
	task automatic modelRun();
		tscPkg::wordT regs [4];
		tscPkg::wordT pc, nextPc, w, a, b, immS, addr;
		bit done;
		regs = '{default: '0};
		pc = '0;
		done = 1'b0;
		expCount = 0;
		storeCount = 0;
		loadCount = 0;
		for (int steps = 0; steps < RUN_TIMEOUT && !done; steps++) begin
			w = imem[pc[11:0]];
			a = regs[w[11:10]];
			b = regs[w[9:8]];
			immS = {{8{w[7]}}, w[7:0]};
			addr = a + immS;
			nextPc = pc + 16'd1;
			case (w[15:12])
				tscPkg::R_OP: begin
					case (w[5:0])
						tscPkg::FUNC_ADD: regs[w[7:6]] = a + b;
						tscPkg::FUNC_SUB: regs[w[7:6]] = a - b;
						tscPkg::FUNC_AND: regs[w[7:6]] = a & b;
						tscPkg::FUNC_ORR: regs[w[7:6]] = a | b;
						tscPkg::FUNC_NOT: regs[w[7:6]] = ~a;
						tscPkg::FUNC_TCP: regs[w[7:6]] = 16'd0 - a;
						tscPkg::FUNC_SHL: regs[w[7:6]] = a << 1;
						tscPkg::FUNC_SHR: regs[w[7:6]] = a >> 1;
						tscPkg::FUNC_JPR: nextPc = a;
						tscPkg::FUNC_JRL: begin
							nextPc = a;
							regs[tscPkg::LINK_REG] = pc + 16'd1;
						end
						tscPkg::FUNC_WWD: begin
							expWwd[expCount] = a;
							expCount++;
						end
						tscPkg::FUNC_HLT: begin
							done = 1'b1;
							expHaltPc = pc + 16'd1; // PC still advances on the HLT edge
						end
						default: ;
					endcase
				end
				tscPkg::ADI_OP: regs[w[9:8]] = addr;
				tscPkg::ORI_OP: regs[w[9:8]] = a | {8'h00, w[7:0]};
				tscPkg::LHI_OP: regs[w[9:8]] = {w[7:0], 8'h00};
				tscPkg::LWD_OP: begin
					regs[w[9:8]] = modelMem.exists(addr) ? modelMem[addr]
						: fillPattern(addr);
					loadAddr[loadCount] = addr;
					loadCount++;
				end
				tscPkg::SWD_OP: begin
					modelMem[addr] = b;
					storeAddr[storeCount] = addr;
					storeVal[storeCount] = b;
					storeCount++;
				end
				tscPkg::BNE_OP: if (a != b) nextPc = pc + 16'd1 + immS;
				tscPkg::BEQ_OP: if (a == b) nextPc = pc + 16'd1 + immS;
				tscPkg::BGZ_OP: if ($signed(a) > 0) nextPc = pc + 16'd1 + immS;
				tscPkg::BLZ_OP: if ($signed(a) < 0) nextPc = pc + 16'd1 + immS;
				tscPkg::JMP_OP: nextPc = {pc[15:12], w[11:0]};
				tscPkg::JAL_OP: begin
					nextPc = {pc[15:12], w[11:0]};
					regs[tscPkg::LINK_REG] = pc + 16'd1;
				end
				default: ;
			endcase
			pc = nextPc;
		end
		if (!done)
			reportPlain("reference model never reached HLT");
	endtask

	// ####################
	// test sequencing
	task automatic runTest(string name);
		int errorsBefore;
		int cycles;
		errorsBefore = errors;
		@(posedge clk);
		rst <= 1'b1;
		@(posedge clk);
		modelRun();
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		cycles = 0;
		@(negedge clk);
		while (!halted && cycles < RUN_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (!halted) begin
			$display("timeout: core did not halt in test %s", name);
			$display("Finished with errors");
			$finish;
		end else begin
			repeat (HALT_WINDOW) @(negedge clk); // nothing may move while halted
			if (wwdIdx != expCount)
				reportPlain($sformatf("%0d of %0d WWD outputs seen", wwdIdx, expCount));
			if (storeIdx != storeCount)
				reportPlain($sformatf("%0d of %0d stores seen", storeIdx, storeCount));
			if (loadIdx != loadCount)
				reportPlain($sformatf("%0d of %0d loads seen", loadIdx, loadCount));
			if (errors == errorsBefore)
				passCount++;
			$display("test %s: %0d outputs, %s", name, expCount,
				errors == errorsBefore ? "ok" : "failed");
		end
	endtask

	initial begin
		rst = 1'b1;
		startProgram();
		wwd(0);
		emit(rInst(tscPkg::FUNC_HLT, 0, 0, 0));
		runTest("reset");
		buildArith();
		runTest("arith");
		buildMemory();
		runTest("memory");
		buildBranches();
		runTest("branch");
		buildJumps();
		runTest("jump");
		buildHalt();
		runTest("halt");
		$display("tests passed: %0d, errors: %0d", passCount, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- tsc.f
hw/tscPkg.sv
hw/fetchUnit.sv
hw/controlUnit.sv
hw/registerFile.sv
hw/alu.sv
hw/memOutUnit.sv
hw/tscCore.sv
verif/tscCoreTb.sv
